// File: logic/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_ADDR_W       16
`define CACHE_WORD_W       32
`define CACHE_BEAT_W       64
`define CACHE_INDEX_W      4                 // 16 lines
`define CACHE_OFFSET_W     4                 // 16-byte line
`define CACHE_BEAT_SEL_W   1                 // 2 beats per line
`define CACHE_TAG_W        (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// front end flow control
`define CACHE_REQ_CREDITS  2

// AXI read channel
`define CACHE_AXI_ID_W        4
`define CACHE_AXI_LEN_W       8
`define CACHE_AXI_ID          0
`define CACHE_AXI_SIZE        3'd3           // 8 bytes per beat
`define CACHE_AXI_BURST_INCR  2'b01
`define CACHE_AXI_RESP_OKAY   2'b00

`endif

// File: logic/cache_addr_pkg.sv
`include "cache_defs.svh"

package cache_addr_pkg;

   // byte address as seen by the requester
   typedef logic [`CACHE_ADDR_W-1:0] byte_addr_t;

   // address fields
   typedef logic [`CACHE_TAG_W-1:0]                     line_tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]                   line_index_t;
   typedef logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0]    line_addr_t;   // tag and index
   typedef logic [`CACHE_BEAT_SEL_W-1:0]                beat_sel_t;

   // data
   typedef logic [`CACHE_WORD_W-1:0] word_t;
   typedef logic [`CACHE_BEAT_W-1:0] beat_t;

endpackage

// File: logic/axi_read_pkg.sv
`include "cache_defs.svh"

package axi_read_pkg;

   // AR channel fields
   typedef logic [`CACHE_AXI_ID_W-1:0]  axi_id_t;
   typedef logic [`CACHE_AXI_LEN_W-1:0] axi_len_t;
   typedef logic [2:0]                  axi_size_t;    // log2 of bytes per beat
   typedef logic [1:0]                  axi_burst_t;
   typedef logic [`CACHE_ADDR_W-1:0]    axi_addr_t;

   // R channel response
   typedef logic [1:0] axi_resp_t;

endpackage

// File: logic/cache_tag_stage.sv
`include "cache_defs.svh"

module cache_tag_stage
   import cache_addr_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset,
   input  logic        req_valid_i,
   input  byte_addr_t  req_addr_i,
   output logic        credit_o,
   output logic        miss_o,
   output line_addr_t  miss_line_o,
   input  logic        replace_i,
   output logic        hit_valid_o,
   output line_index_t hit_index_o,
   output beat_sel_t   hit_beat_o,
   output logic        hit_word_o
);

   localparam int DEPTH  = `CACHE_REQ_CREDITS;
   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int NLINES = 2 ** `CACHE_INDEX_W;
   localparam int WSEL   = `CACHE_OFFSET_W - `CACHE_BEAT_SEL_W - 1;   // word select bit

   typedef enum logic {TS_RUN, TS_WAIT} tag_state_t;

   tag_state_t        state;
   byte_addr_t        buf_q [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              buf_empty;
   logic              pop;
   logic              stall;
   logic              hit;
   logic              refill_done;
   logic              replace_q;
   logic              lk_valid;
   byte_addr_t        lk_addr;
   line_tag_t         lk_tag;
   line_index_t       lk_index;
   line_tag_t         tag_q [NLINES];
   logic [NLINES-1:0] valid_q;

   assign buf_empty = (count == '0);

   // lookup fields
   assign lk_tag   = lk_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign lk_index = lk_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   assign hit   = (state == TS_RUN) && lk_valid && valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
   assign stall = lk_valid && !hit;     // a missed request holds the lookup register
   assign pop   = !buf_empty && !stall;

   assign miss_o      = (state == TS_RUN) && lk_valid && !hit;   // single cycle, state moves on
   assign miss_line_o = lk_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

   assign refill_done = (state == TS_WAIT) && replace_q && !replace_i;

   assign hit_valid_o = hit;
   assign hit_index_o = lk_index;
   assign hit_beat_o  = lk_addr[`CACHE_OFFSET_W-1 -: `CACHE_BEAT_SEL_W];
   assign hit_word_o  = lk_addr[WSEL];

   // request buffer storage, space is guaranteed by the credits
   always_ff @(posedge clk_i) begin
      if (req_valid_i) buf_q[wr_ptr] <= req_addr_i;
      if (pop)         lk_addr <= buf_q[rd_ptr];
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         credit_o  <= 1'b0;
         lk_valid  <= 1'b0;
         replace_q <= 1'b0;
      end else begin
         if (req_valid_i) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)         rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count     <= count + CNT_W'(req_valid_i) - CNT_W'(pop);
         credit_o  <= pop;                      // one credit per slot freed
         replace_q <= replace_i;
         if (!stall) lk_valid <= !buf_empty;
      end
   end

   // miss handling and tag array update
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state   <= TS_RUN;
         valid_q <= '0;
         for (int i = 0; i < NLINES; i++) tag_q[i] <= '0;
      end else begin
         case (state)
            TS_RUN:  if (miss_o) state <= TS_WAIT;
            default: begin
               if (refill_done) begin
                  tag_q[lk_index]   <= lk_tag;
                  valid_q[lk_index] <= 1'b1;
                  state             <= TS_RUN;   // stalled lookup is retried next cycle
               end
            end
         endcase
      end
   end

endmodule

// File: logic/cache_refill_axi.sv
`include "cache_defs.svh"

module cache_refill_axi
   import cache_addr_pkg::*;
   import axi_read_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset,
   input  logic        replace_valid_i,
   input  line_addr_t  replace_line_i,
   output logic        replace_o,
   output logic        fill_valid_o,
   output line_index_t fill_index_o,
   output beat_sel_t   fill_beat_o,
   output beat_t       fill_data_o,
   // AXI read address channel
   output logic        ar_valid_o,
   input  logic        ar_ready_i,
   output axi_addr_t   ar_addr_o,
   output axi_len_t    ar_len_o,
   output axi_size_t   ar_size_o,
   output axi_burst_t  ar_burst_o,
   output axi_id_t     ar_id_o,
   // AXI read data channel
   input  logic        r_valid_i,
   output logic        r_ready_o,
   input  beat_t       r_data_i,
   input  axi_resp_t   r_resp_i,
   input  logic        r_last_i
);

   localparam int BEATS = 2 ** `CACHE_BEAT_SEL_W;

   typedef enum logic [1:0] {
      RF_IDLE,
      RF_ADDR,
      RF_LOAD,
      RF_END
   } refill_state_t;

   refill_state_t state;
   line_addr_t    line_q;
   beat_sel_t     beat_cnt;
   logic          slave_err;   // sticky over the burst, a burst cannot be cut short

   // burst fields, one line per burst
   assign ar_addr_o  = axi_addr_t'({line_q, {`CACHE_OFFSET_W{1'b0}}});
   assign ar_len_o   = axi_len_t'(BEATS - 1);
   assign ar_size_o  = `CACHE_AXI_SIZE;
   assign ar_burst_o = `CACHE_AXI_BURST_INCR;
   assign ar_id_o    = axi_id_t'(`CACHE_AXI_ID);

   assign ar_valid_o = (state == RF_ADDR);
   assign r_ready_o  = (state == RF_LOAD);
   assign replace_o  = (state != RF_IDLE);

   // every accepted beat goes straight into the line store
   assign fill_valid_o = (state == RF_LOAD) && r_valid_i;
   assign fill_index_o = line_q[`CACHE_INDEX_W-1:0];
   assign fill_beat_o  = beat_cnt;
   assign fill_data_o  = r_data_i;

   always_ff @(posedge clk_i) begin
      if (state == RF_IDLE && replace_valid_i) line_q <= replace_line_i;
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state     <= RF_IDLE;
         beat_cnt  <= '0;
         slave_err <= 1'b0;
      end else begin
         case (state)
            RF_IDLE: begin
               if (replace_valid_i) state <= RF_ADDR;
            end
            RF_ADDR: begin
               beat_cnt  <= '0;
               slave_err <= 1'b0;
               if (ar_ready_i) state <= RF_LOAD;   // address held until accepted
            end
            RF_LOAD: begin
               if (r_valid_i) begin
                  if (r_resp_i != `CACHE_AXI_RESP_OKAY) slave_err <= 1'b1;
                  if (r_last_i) state <= RF_END;
                  else          beat_cnt <= beat_cnt + 1'b1;
               end
            end
            default: begin
               // one cycle for the last store write to settle
               state <= slave_err ? RF_ADDR : RF_IDLE;
            end
         endcase
      end
   end

endmodule

// File: logic/cache_line_store.sv
`include "cache_defs.svh"

module cache_line_store
   import cache_addr_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset,
   input  logic        fill_valid_i,
   input  line_index_t fill_index_i,
   input  beat_sel_t   fill_beat_i,
   input  beat_t       fill_data_i,
   input  logic        hit_valid_i,
   input  line_index_t hit_index_i,
   input  beat_sel_t   hit_beat_i,
   input  logic        hit_word_i,
   output logic        rsp_valid_o,
   output word_t       rsp_data_o
);

   localparam int ENTRY_W = `CACHE_INDEX_W + `CACHE_BEAT_SEL_W;
   localparam int ENTRIES = 2 ** ENTRY_W;    // one entry per beat

   beat_t              mem [ENTRIES];
   logic [ENTRY_W-1:0] wr_entry;
   logic [ENTRY_W-1:0] rd_entry;
   beat_t              rd_beat;

   assign wr_entry = {fill_index_i, fill_beat_i};
   assign rd_entry = {hit_index_i, hit_beat_i};
   assign rd_beat  = mem[rd_entry];

   always_ff @(posedge clk_i) begin
      if (fill_valid_i) mem[wr_entry] <= fill_data_i;
   end

   // lower half holds the lower address
   always_ff @(posedge clk_i) begin
      if (hit_valid_i) rsp_data_o <= hit_word_i ? rd_beat[`CACHE_BEAT_W-1 -: `CACHE_WORD_W]
                                                : rd_beat[`CACHE_WORD_W-1:0];
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) rsp_valid_o <= 1'b0;
      else       rsp_valid_o <= hit_valid_i;
   end

endmodule

// File: logic/cache_ro_top.sv
module cache_ro_top
   import cache_addr_pkg::*;
   import axi_read_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset,
   // front end
   input  logic       req_valid_i,
   input  byte_addr_t req_addr_i,
   output logic       credit_o,
   output logic       rsp_valid_o,
   output word_t      rsp_data_o,
   // AXI read channel
   output logic       ar_valid_o,
   input  logic       ar_ready_i,
   output axi_addr_t  ar_addr_o,
   output axi_len_t   ar_len_o,
   output axi_size_t  ar_size_o,
   output axi_burst_t ar_burst_o,
   output axi_id_t    ar_id_o,
   input  logic       r_valid_i,
   output logic       r_ready_o,
   input  beat_t      r_data_i,
   input  axi_resp_t  r_resp_i,
   input  logic       r_last_i
);

   logic        miss;
   line_addr_t  miss_line;
   logic        replace;
   logic        fill_valid;
   line_index_t fill_index;
   beat_sel_t   fill_beat;
   beat_t       fill_data;
   logic        hit_valid;
   line_index_t hit_index;
   beat_sel_t   hit_beat;
   logic        hit_word;

   cache_tag_stage tag0 (
      .clk_i       (clk_i),
      .reset       (reset),
      .req_valid_i (req_valid_i),
      .req_addr_i  (req_addr_i),
      .credit_o    (credit_o),
      .miss_o      (miss),
      .miss_line_o (miss_line),
      .replace_i   (replace),
      .hit_valid_o (hit_valid),
      .hit_index_o (hit_index),
      .hit_beat_o  (hit_beat),
      .hit_word_o  (hit_word)
   );

   cache_refill_axi refill0 (
      .clk_i           (clk_i),
      .reset           (reset),
      .replace_valid_i (miss),
      .replace_line_i  (miss_line),
      .replace_o       (replace),
      .fill_valid_o    (fill_valid),
      .fill_index_o    (fill_index),
      .fill_beat_o     (fill_beat),
      .fill_data_o     (fill_data),
      .ar_valid_o      (ar_valid_o),
      .ar_ready_i      (ar_ready_i),
      .ar_addr_o       (ar_addr_o),
      .ar_len_o        (ar_len_o),
      .ar_size_o       (ar_size_o),
      .ar_burst_o      (ar_burst_o),
      .ar_id_o         (ar_id_o),
      .r_valid_i       (r_valid_i),
      .r_ready_o       (r_ready_o),
      .r_data_i        (r_data_i),
      .r_resp_i        (r_resp_i),
      .r_last_i        (r_last_i)
   );

   cache_line_store store0 (
      .clk_i        (clk_i),
      .reset        (reset),
      .fill_valid_i (fill_valid),
      .fill_index_i (fill_index),
      .fill_beat_i  (fill_beat),
      .fill_data_i  (fill_data),
      .hit_valid_i  (hit_valid),
      .hit_index_i  (hit_index),
      .hit_beat_i   (hit_beat),
      .hit_word_i   (hit_word),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_data_o   (rsp_data_o)
   );

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset held for a fixed number of rising edges
   initial begin
      reset_o <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

// File: verification/cache_ro_tb.sv
`include "cache_defs.svh"

module cache_ro_tb
   import cache_addr_pkg::*;
   import axi_read_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HIT_LATENCY   = 3;   // drive edge to response edge
   localparam int RSP_TIMEOUT   = 2000;
   localparam int DRAIN_TIMEOUT = 50;
   localparam int RESET_TIMEOUT = 100;

   typedef logic [8*24-1:0] test_name_t;

   logic       clk;
   logic       reset;
   logic       req_valid;
   byte_addr_t req_addr;
   logic       credit;
   logic       rsp_valid;
   word_t      rsp_data;
   logic       ar_valid;
   logic       ar_ready;
   axi_addr_t  ar_addr;
   axi_len_t   ar_len;
   axi_size_t  ar_size;
   axi_burst_t ar_burst;
   axi_id_t    ar_id;
   logic       r_valid;
   logic       r_ready;
   beat_t      r_data;
   axi_resp_t  r_resp;
   logic       r_last;

   // test table from the input file
   test_name_t names[$];
   byte_addr_t addrs[$];
   int         err_codes[$];
   word_t      exp_words[$];
   int         exp_ars[$];

   int          errors;
   int          tests;
   int          failed_tests;
   int          credits;
   logic        timed_out;
   int          err_beat;       // beat that gets SLVERR in the current test
   int          err_gen;
   logic [15:0] lfsr;           // owned by the AXI model
   int          ar_count;
   int          model_errors;
   int          err_served;

   tb_clock_gen clk0 (
      .clk_o   (clk),
      .reset_o (reset)
   );

   cache_ro_top dut0 (
      .clk_i       (clk),
      .reset       (reset),
      .req_valid_i (req_valid),
      .req_addr_i  (req_addr),
      .credit_o    (credit),
      .rsp_valid_o (rsp_valid),
      .rsp_data_o  (rsp_data),
      .ar_valid_o  (ar_valid),
      .ar_ready_i  (ar_ready),
      .ar_addr_o   (ar_addr),
      .ar_len_o    (ar_len),
      .ar_size_o   (ar_size),
      .ar_burst_o  (ar_burst),
      .ar_id_o     (ar_id),
      .r_valid_i   (r_valid),
      .r_ready_o   (r_ready),
      .r_data_i    (r_data),
      .r_resp_i    (r_resp),
      .r_last_i    (r_last)
   );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // inverted address in the upper half and the address in the lower half
   function automatic word_t mem_word(input axi_addr_t a);
      return {~a, a};
   endfunction

   task automatic draw_bit(output logic b);
      lfsr = lfsr_step(lfsr);
      b    = lfsr[0];
   endtask

   task automatic check_word(input test_name_t name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("Mismatch in %0s: expected word %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_count(input test_name_t name, input int exp, input int act);
      if (act != exp) begin
         $display("Mismatch in %0s: expected %0d AR handshakes, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_latency(input test_name_t name, input int exp, input int act);
      if (act != exp) begin
         $display("Mismatch in %0s: expected hit latency %0d, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   // AXI read slave that answers each address with two beats and random gaps
   initial begin : axi_slave_model
      logic       ar_valid_s;
      logic       r_ready_s;
      axi_addr_t  ar_addr_s;
      axi_len_t   ar_len_s;
      axi_size_t  ar_size_s;
      axi_burst_t ar_burst_s;
      axi_id_t    ar_id_s;
      axi_addr_t  burst_addr;
      logic       burst_active;
      logic       presenting;
      logic       coin;
      int         beat_idx;
      lfsr         = 16'd13166;
      ar_count     = 0;
      model_errors = 0;
      err_served   = 0;
      burst_addr   = '0;
      burst_active = 1'b0;
      presenting   = 1'b0;
      beat_idx     = 0;
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      r_data   <= '0;
      r_resp   <= 2'b00;
      r_last   <= 1'b0;
      forever begin
         @(negedge clk);
         ar_valid_s = ar_valid;
         r_ready_s  = r_ready;
         ar_addr_s  = ar_addr;
         ar_len_s   = ar_len;
         ar_size_s  = ar_size;
         ar_burst_s = ar_burst;
         ar_id_s    = ar_id;
         @(posedge clk);
         if (ar_valid_s && ar_ready) begin
            ar_count++;
            if (ar_len_s != 8'd1 || ar_size_s != 3'd3 || ar_burst_s != 2'b01 ||
                ar_addr_s[3:0] != 4'h0 || ar_id_s != axi_id_t'(`CACHE_AXI_ID)) begin
               $display("AR at %h is not a two-beat incrementing line burst with the fixed id",
                        ar_addr_s);
               model_errors++;
            end
            burst_addr   = ar_addr_s;
            beat_idx     = 0;
            burst_active = 1'b1;
            ar_ready <= 1'b0;
         end else if (ar_valid_s) begin
            draw_bit(coin);
            ar_ready <= coin;
         end
         if (presenting && r_ready_s) begin   // beat taken at this edge
            if (r_last) burst_active = 1'b0;
            beat_idx++;
            presenting = 1'b0;
            r_valid <= 1'b0;
         end
         if (burst_active && !presenting) begin
            draw_bit(coin);
            if (coin) begin
               presenting = 1'b1;
               r_valid <= 1'b1;
               r_data  <= {mem_word(burst_addr + 16'(beat_idx * 8 + 4)),
                           mem_word(burst_addr + 16'(beat_idx * 8))};
               r_last  <= (beat_idx == 1);
               if (err_beat == beat_idx + 1 && err_served != err_gen) begin
                  r_resp <= 2'b10;     // SLVERR once per test
                  err_served = err_gen;
               end else begin
                  r_resp <= 2'b00;
               end
            end
         end
      end
   end

   // issue one group of requests back to back as credits allow
   task automatic run_test(input int first, input int n);
      int issued;
      int got;
      int cycles;
      int ar_start;
      int err_start;
      int exp_ar;
      int lat;
      int issue_cyc[$];
      issued    = 0;
      got       = 0;
      cycles    = 0;
      exp_ar    = 0;
      ar_start  = ar_count;
      err_start = errors + model_errors;
      for (int k = 0; k < n; k++) exp_ar += exp_ars[first + k];
      err_beat = err_codes[first];
      err_gen++;
      while (got < n && cycles < RSP_TIMEOUT) begin
         @(posedge clk);
         if (issued < n && credits > 0) begin
            req_valid <= 1'b1;
            req_addr  <= addrs[first + issued];
            issue_cyc.push_back(cycles);
            credits--;
            issued++;
         end else begin
            req_valid <= 1'b0;
         end
         @(negedge clk);
         cycles++;
         if (credit) credits++;
         if (credit && (ar_valid || r_ready)) begin
            $display("credit came back while a refill was running in %0s", names[first]);
            errors++;
         end
         if (credits > `CACHE_REQ_CREDITS) begin
            $display("more credits returned than were spent in %0s", names[first]);
            errors++;
            credits = `CACHE_REQ_CREDITS;
         end
         if (rsp_valid && got >= issued) begin
            $display("response without a request in %0s", names[first]);
            errors++;
         end else if (rsp_valid) begin
            check_word(names[first], exp_words[first + got], rsp_data);
            lat = cycles - issue_cyc[got] - 1;
            if (n == 1 && exp_ar == 0) check_latency(names[first], HIT_LATENCY, lat);
            got++;
         end
      end
      @(posedge clk);
      req_valid <= 1'b0;
      if (got < n) begin
         $display("timeout in %0s: %0d of %0d responses arrived", names[first], got, n);
         timed_out = 1'b1;
      end else begin
         cycles = 0;
         while (credits < `CACHE_REQ_CREDITS && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (credit) credits++;
         end
         if (credits < `CACHE_REQ_CREDITS) begin
            $display("not all credits came back after %0s", names[first]);
            errors++;
         end
         check_count(names[first], exp_ar, ar_count - ar_start);
      end
      tests++;
      if (errors + model_errors == err_start && got == n) begin
         $display("test %0s: ok", names[first]);
      end else begin
         failed_tests++;
         $display("test %0s: %0d error(s)", names[first], errors + model_errors - err_start);
      end
   endtask

   initial begin : test_sequence
      int         fd;
      int         cnt;
      int         i;
      int         n;
      int         wait_cycles;
      string      line;
      test_name_t name_v;
      byte_addr_t addr_v;
      int         err_v;
      word_t      exp_v;
      int         ar_v;
      req_valid <= 1'b0;
      req_addr  <= '0;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      credits      = `CACHE_REQ_CREDITS;
      timed_out    = 1'b0;
      err_beat     = 0;
      err_gen      = 0;

      fd = $fopen("verification/cache_ro_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open verification/cache_ro_input.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.getc(0) != "#") begin
               if ($sscanf(line, "%s %h %d %h %d",
                           name_v, addr_v, err_v, exp_v, ar_v) == 5) begin
                  names.push_back(name_v);
                  addrs.push_back(addr_v);
                  err_codes.push_back(err_v);
                  exp_words.push_back(exp_v);
                  exp_ars.push_back(ar_v);
               end
            end
         end
         $fclose(fd);
      end

      wait_cycles = 0;
      do begin
         @(posedge clk);
         wait_cycles++;
      end while (reset && wait_cycles < RESET_TIMEOUT);
      if (reset) begin
         $display("reset was never released");
         timed_out = 1'b1;
      end

      // consecutive lines with the same name make one test
      i = 0;
      while (i < names.size() && !timed_out) begin
         n = 1;
         while (i + n < names.size() && names[i + n] == names[i]) n++;
         run_test(i, n);
         i += n;
      end

      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors + model_errors);
      if (errors + model_errors == 0 && !timed_out && tests > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+logic
logic/cache_addr_pkg.sv
logic/axi_read_pkg.sv
logic/cache_tag_stage.sv
logic/cache_refill_axi.sv
logic/cache_line_store.sv
logic/cache_ro_top.sv
verification/tb_clock_gen.sv
verification/cache_ro_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   -f src.f --top-module cache_ro_tb -Mdir "$BUILD_DIR" -o cache_ro_sim

"./$BUILD_DIR/cache_ro_sim" | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
   echo "simulation reported a failure, see $LOG"
   exit 1
fi
echo "simulation finished without failures"

// File: verification/cache_ro_input.txt
# name  byte_addr  error_beat (0 none, 1 or 2 returns SLVERR once)  expected_word  expected_ar
# lines that share a name form one test and are issued back to back
cold_miss        0100 0 FEFF0100 1
same_line_hit    0108 0 FEF70108 0
line_hit_upper   010C 0 FEF3010C 0
evict_other_tag  1100 0 EEFF1100 1
evict_back       0104 0 FEFB0104 1
evict_again      1104 0 EEFB1104 1
slverr_beat1     0230 1 FDCF0230 2
slverr_hit       023C 0 FDC3023C 0
slverr_beat2     0348 2 FCB70348 2
credit_queue     0500 0 FAFF0500 1
credit_queue     0504 0 FAFB0504 0
credit_queue     050C 0 FAF3050C 0
stall_miss_a     0FF0 0 F00F0FF0 1
stall_miss_b     ABCC 0 5433ABCC 1
stall_miss_c     7F78 0 80877F78 1
stall_hit        0FF4 0 F00B0FF4 0
